//--- decodeHazard.sv
//~~~~~~~~~~~~~~~~~~~~
// Decode stage forwarding and load-use hazard block
// Register file, ALU and data cache live outside
// stageData words must belong to the instructions in track
// No handshake, all valids and stallReq are levels
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "hazard_params.svh"

module decodeHazard (
	input  logic                            clk,
	input  logic                            rst_n,
	input  hazardPkg::decodeInfoT           decode,
	input  logic [`NUM_SRC-1:0][`XLEN-1:0] rfData,
	input  hazardPkg::stageDataT            stageData,
	output logic                            stallReq,
	output hazardPkg::issueT                issue
);
	import hazardPkg::*;

	trackT                           track;
	logic [`NUM_SRC-1:0][`XLEN-1:0] operand;
	logic [`NUM_SRC-1:0]             exLoadHit;

	// In-flight destinations
	stageTracker stageTracker_i (
		.clk   (clk),
		.rst_n (rst_n),
		.decode(decode),
		.stall (stallReq),
		.track (track)
	);

	// One forwarder per source operand
	for (genvar i = 0; i < `NUM_SRC; i++) begin : genFwd
		operandForward operandForward_i (
			.clk      (clk),
			.rst_n    (rst_n),
			.srcAddr  (decode.src[i]),
			.track    (track),
			.rfData   (rfData[i]),
			.stageData(stageData),
			.operand  (operand[i]),
			.exLoadHit(exLoadHit[i])
		);
	end

	issueRegister issueRegister_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.decode   (decode),
		.operand  (operand),
		.exLoadHit(exLoadHit),
		.stallReq (stallReq),
		.issue    (issue)
	);

endmodule

//--- hazardPkg.sv
//~~~~~~~~~~~~~~~~~~~~
// Types shared by the decode hazard block
// Widths follow the macros of the params header
// A stage entry with wbEn low is a bubble
//~~~~~~~~~~~~~~~~~~~~
`include "hazard_params.svh"

package hazardPkg;

	// Instruction presented by decode
	typedef struct packed {
		logic                                 valid;
		logic [`NUM_SRC-1:0][`REG_ADDR_W-1:0] src;
		logic [`REG_ADDR_W-1:0]               dest;
		logic                                 wbEn;
		logic                                 isLoad;
	} decodeInfoT;

	// One instruction still in flight
	typedef struct packed {
		logic [`REG_ADDR_W-1:0] dest;
		logic                   wbEn;
		logic                   isLoad;
	} stageEntryT;

	typedef struct packed {
		stageEntryT ex;
		stageEntryT mem;
		stageEntryT wb;
	} trackT;

	// Words that can be forwarded back to decode
	typedef struct packed {
		logic [`XLEN-1:0] exAlu;
		logic [`XLEN-1:0] memAlu;
		logic [`XLEN-1:0] dcacheRd;
		logic [`XLEN-1:0] wbData;
	} stageDataT;

	typedef enum logic [2:0] {
		SEL_RF,
		SEL_EX,
		SEL_MEM_ALU,
		SEL_DCACHE,
		SEL_WB
	} operandSelT;

	// ID/EX register contents
	typedef struct packed {
		logic                            valid;
		logic [`NUM_SRC-1:0][`XLEN-1:0] operand;
		logic [`REG_ADDR_W-1:0]          dest;
		logic                            wbEn;
		logic                            isLoad;
	} issueT;

endpackage

//--- hazard_params.svh
//~~~~~~~~~~~~~~~~~~~~
// Sizes for the decode hazard block
// Only the register file sizes of RV32I were exercised
// NUM_SRC scales the generate loop of forwarders
//~~~~~~~~~~~~~~~~~~~~
`ifndef HAZARD_PARAMS_SVH
`define HAZARD_PARAMS_SVH

// Integer register word
`define XLEN 32

// Addresses x0 to x31
`define REG_ADDR_W 5

// Read ports per decoded instruction
`define NUM_SRC 2

`endif

//--- issueRegister.sv
//~~~~~~~~~~~~~~~~~~~~
// Stall request and the ID/EX register
// stallReq is combinational from decode and the forwarders
// Decode must hold its record while stallReq is high
// Only the valid bit of the bundle is reset
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "hazard_params.svh"

module issueRegister (
	input  logic                            clk,
	input  logic                            rst_n,
	input  hazardPkg::decodeInfoT           decode,
	input  logic [`NUM_SRC-1:0][`XLEN-1:0] operand,
	input  logic [`NUM_SRC-1:0]             exLoadHit,
	output logic                            stallReq,
	output hazardPkg::issueT                issue
);
	import hazardPkg::*;

	logic                            validQ;
	logic [`NUM_SRC-1:0][`XLEN-1:0] operandQ;
	logic [`REG_ADDR_W-1:0]          destQ;
	logic                            wbEnQ;
	logic                            isLoadQ;
	logic                            issueNow;

	// Any operand waiting on a load in EX
	assign stallReq = decode.valid && (|exLoadHit);
	assign issueNow = decode.valid && !stallReq;

	always_ff @(posedge clk) begin
		if (!rst_n)
			validQ <= 1'b0;
		else
			validQ <= issueNow;
	end

	// Payload only moves on an issue
	always_ff @(posedge clk) begin
		if (issueNow) begin
			operandQ <= operand;
			destQ    <= decode.dest;
			wbEnQ    <= decode.wbEn;
			isLoadQ  <= decode.isLoad;
		end
	end

	assign issue = '{valid: validQ, operand: operandQ, dest: destQ,
		wbEn: wbEnQ, isLoad: isLoadQ};

	// Decode holds its record through a stall
	decodeHeldOnStall: assert property (@(posedge clk) disable iff (!rst_n)
		stallReq |=> $stable(decode))
	else
		$error("decode changed while stallReq was high");

endmodule

//--- operandForward.sv
//~~~~~~~~~~~~~~~~~~~~
// Forwarding mux for one source operand
// Newest producer wins, EX before MEM before WB
// x0 always reads the register file
// rfData must be read for the same srcAddr this cycle
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "hazard_params.svh"

module operandForward (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`REG_ADDR_W-1:0] srcAddr,
	input  hazardPkg::trackT       track,
	input  logic [`XLEN-1:0]       rfData,
	input  hazardPkg::stageDataT   stageData,
	output logic [`XLEN-1:0]       operand,
	output logic                   exLoadHit
);
	import hazardPkg::*;

	operandSelT sel;

	// Stage writes the register we are reading
	function automatic logic stageHit(input stageEntryT entry,
		input logic [`REG_ADDR_W-1:0] addr);
		return entry.wbEn && (entry.dest == addr);
	endfunction

	// Source select by priority
	always_comb begin
		if (srcAddr == '0) begin
			sel = SEL_RF;
		end else if (stageHit(track.ex, srcAddr)) begin
			sel = SEL_EX;
		end else if (stageHit(track.mem, srcAddr)) begin
			// Load data only exists after the cache read
			sel = track.mem.isLoad ? SEL_DCACHE : SEL_MEM_ALU;
		end else if (stageHit(track.wb, srcAddr)) begin
			sel = SEL_WB;
		end else begin
			sel = SEL_RF;
		end
	end

	// Operand word
	always_comb begin
		case (sel)
			SEL_EX:      operand = stageData.exAlu;
			SEL_MEM_ALU: operand = stageData.memAlu;
			SEL_DCACHE:  operand = stageData.dcacheRd;
			SEL_WB:      operand = stageData.wbData;
			default:     operand = rfData;
		endcase
	end

	// Load still in EX has no data yet
	assign exLoadHit = (sel == SEL_EX) && track.ex.isLoad;

	// Stalled load reaches MEM next cycle, where the retry finds dcacheRd
	loadMovesToMem: assert property (@(posedge clk) disable iff (!rst_n)
		exLoadHit |=> (track.mem.wbEn && track.mem.isLoad &&
			(track.mem.dest == $past(srcAddr))))
	else
		$error("load hit in EX did not move to MEM");

endmodule

//--- run.sh
#!/bin/sh
# Build and run the decode hazard testbench with Verilator
# Pass or fail comes from the simulation log

cd "$(dirname "$0")" || exit 1

TOP=tb_decodeHazard
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module "$TOP" -Mdir "$BUILD_DIR" -f src.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
	echo "Simulation reported a failure, see $LOG"
	exit 1
fi

if [ $simStatus -ne 0 ]; then
	echo "Simulator exited with status $simStatus"
	exit 1
fi

if ! grep -q "TEST PASS" "$LOG"; then
	echo "No result line found in $LOG"
	exit 1
fi

echo "Simulation passed"
exit 0

//--- src.f
+incdir+.
hazardPkg.sv
stageTracker.sv
operandForward.sv
issueRegister.sv
decodeHazard.sv
tb_decodeHazard.sv

//--- stageTracker.sv
//~~~~~~~~~~~~~~~~~~~~
// Destination records of the EX, MEM and WB stages
// All three shift every cycle, there is no downstream stall
// A stalled or invalid decode enters a bubble into EX
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "hazard_params.svh"

module stageTracker (
	input  logic                  clk,
	input  logic                  rst_n,
	input  hazardPkg::decodeInfoT decode,
	input  logic                  stall,
	output hazardPkg::trackT      track
);
	import hazardPkg::*;

	localparam stageEntryT BUBBLE = '0;

	stageEntryT exNext;

	// Record entering EX on the next edge
	always_comb begin
		if (decode.valid && !stall) begin
			exNext.dest = decode.dest;
			exNext.wbEn = decode.wbEn;
			// A load that writes nothing cannot cause a load-use stall
			exNext.isLoad = decode.isLoad && decode.wbEn;
		end else begin
			exNext = BUBBLE;
		end
	end

	// Stage shift
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			track.ex  <= BUBBLE;
			track.mem <= BUBBLE;
			track.wb  <= BUBBLE;
		end else begin
			track.ex  <= exNext;
			track.mem <= track.ex;
			track.wb  <= track.mem;
		end
	end

	// Only a load waiting in EX may hold decode
	stallOnlyOnLoad: assert property (@(posedge clk) disable iff (!rst_n)
		stall |-> (track.ex.wbEn && track.ex.isLoad))
	else
		$error("stall requested without a load in EX");

endmodule

//--- tb_decodeHazard.sv
//~~~~~~~~~~~~~~~~~~~~
// Random testbench for decodeHazard
// Keeps its own EX, MEM and WB records and applies the forwarding rules
// stageData words are random and belong to the records by position
// Decode is held while the model expects a stall
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "hazard_params.svh"

module tb_decodeHazard;
	import hazardPkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int NUM_CYCLES   = 2000;
	localparam int CLK_PERIOD   = 20;
	localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_CYCLES + 20) * CLK_PERIOD;

	logic                            clk;
	logic                            rst_n;
	decodeInfoT                      decode;
	logic [`NUM_SRC-1:0][`XLEN-1:0] rfData;
	stageDataT                       stageData;
	logic                            stallReq;
	issueT                           issue;

	integer seed = 67672;

	// Model records of the instructions in flight
	stageEntryT mEx;
	stageEntryT mMem;
	stageEntryT mWb;

	int selSeen [0:4];
	int stallCount;

	decodeHazard decodeHazard_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.decode   (decode),
		.rfData   (rfData),
		.stageData(stageData),
		.stallReq (stallReq),
		.issue    (issue)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic stopOnError();
		$display("TEST FAIL");
		$fatal(1, "stopping at the first mismatch");
	endtask

	task automatic checkStall(input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("** Error at %0t ns: stallReq expected %0b, actual %0b",
				$time, expected, actual);
			stopOnError();
		end
	endtask

	task automatic checkIssue(input issueT expected, input issueT actual);
		if (actual.valid !== expected.valid) begin
			$display("** Error at %0t ns: issue.valid expected %0b, actual %0b",
				$time, expected.valid, actual.valid);
			stopOnError();
		end else if (expected.valid && actual !== expected) begin
			$display("** Error at %0t ns: issue expected %h, actual %h",
				$time, expected, actual);
			stopOnError();
		end
	endtask

	// Mostly valid, small address range so hazards are common
	task automatic makeDecode();
		logic [31:0] r;
		r = $random(seed);
		decode.valid  = (r[2:0] != 3'd0);
		decode.wbEn   = (r[5:3] != 3'd0);
		decode.isLoad = (r[7:6] == 2'd0);
		decode.dest   = `REG_ADDR_W'(r[10:8]);
		for (int i = 0; i < `NUM_SRC; i++) begin
			r = $random(seed);
			decode.src[i] = `REG_ADDR_W'(r[2:0]);
		end
	endtask

	task automatic makeData();
		for (int i = 0; i < `NUM_SRC; i++)
			rfData[i] = $random(seed);
		stageData.exAlu    = $random(seed);
		stageData.memAlu   = $random(seed);
		stageData.dcacheRd = $random(seed);
		stageData.wbData   = $random(seed);
	endtask

	// Newest writer of register a, x0 never forwarded
	function automatic operandSelT pickSource(input logic [`REG_ADDR_W-1:0] a);
		if (a == '0)
			return SEL_RF;
		if (mEx.wbEn && mEx.dest == a)
			return SEL_EX;
		if (mMem.wbEn && mMem.dest == a)
			return mMem.isLoad ? SEL_DCACHE : SEL_MEM_ALU;
		if (mWb.wbEn && mWb.dest == a)
			return SEL_WB;
		return SEL_RF;
	endfunction

	function automatic logic [`XLEN-1:0] sourceWord(input operandSelT s,
		input logic [`XLEN-1:0] rf);
		case (s)
			SEL_EX:      return stageData.exAlu;
			SEL_MEM_ALU: return stageData.memAlu;
			SEL_DCACHE:  return stageData.dcacheRd;
			SEL_WB:      return stageData.wbData;
			default:     return rf;
		endcase
	endfunction

	// Clock edge of the model pipeline
	task automatic advanceModel(input logic issued);
		mWb  = mMem;
		mMem = mEx;
		if (issued) begin
			mEx.dest   = decode.dest;
			mEx.wbEn   = decode.wbEn;
			mEx.isLoad = decode.isLoad;
		end else begin
			mEx = '0;
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the random run finished");
		$display("TEST FAIL");
		$fatal(1, "timeout");
	end

	initial begin
		operandSelT sel;
		issueT      expIssue;
		logic       expStall;
		logic       holdDecode;
		logic       coverageGap;

		clk       = 1'b0;
		rst_n     = 1'b0;
		decode    = '0;
		rfData    = '0;
		stageData = '0;
		mEx       = '0;
		mMem      = '0;
		mWb       = '0;
		for (int k = 0; k < 5; k++)
			selSeen[k] = 0;
		stallCount  = 0;
		holdDecode  = 1'b0;
		coverageGap = 1'b0;
		expIssue    = '0;

		// Valid load reading its own destination, only stalls if EX is not a bubble
		decode.valid  = 1'b1;
		decode.wbEn   = 1'b1;
		decode.isLoad = 1'b1;
		decode.dest   = `REG_ADDR_W'(1);
		for (int i = 0; i < `NUM_SRC; i++)
			decode.src[i] = `REG_ADDR_W'(1);

		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;
		// Idle after reset
		checkStall(1'b0, stallReq);
		checkIssue(expIssue, issue);

		for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
			if (!holdDecode)
				makeDecode();
			makeData();

			expStall = 1'b0;
			expIssue = '0;
			for (int i = 0; i < `NUM_SRC; i++) begin
				sel = pickSource(decode.src[i]);
				expIssue.operand[i] = sourceWord(sel, rfData[i]);
				// Load result not available until MEM
				if (sel == SEL_EX && mEx.isLoad)
					expStall = 1'b1;
				if (decode.valid)
					selSeen[sel]++;
			end
			expStall        = expStall && decode.valid;
			expIssue.valid  = decode.valid && !expStall;
			expIssue.dest   = decode.dest;
			expIssue.wbEn   = decode.wbEn;
			expIssue.isLoad = decode.isLoad;
			if (expStall)
				stallCount++;

			#1;
			checkStall(expStall, stallReq);
			@(posedge clk);
			#2;
			checkIssue(expIssue, issue);
			advanceModel(expIssue.valid);
			holdDecode = expStall;
		end

		$display("Stalls %0d, EX %0d, MEM ALU %0d, DCACHE %0d, WB %0d", stallCount,
			selSeen[SEL_EX], selSeen[SEL_MEM_ALU], selSeen[SEL_DCACHE], selSeen[SEL_WB]);
		if (stallCount == 0) begin
			$display("No load-use stall happened during the run");
			coverageGap = 1'b1;
		end
		if (selSeen[SEL_EX] == 0 || selSeen[SEL_MEM_ALU] == 0 ||
			selSeen[SEL_DCACHE] == 0 || selSeen[SEL_WB] == 0) begin
			$display("Some forwarding source was never selected");
			coverageGap = 1'b1;
		end

		if (coverageGap) begin
			$display("TEST FAIL");
			$fatal(1, "stimulus did not reach every case");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule
